// ==== files.f ====
+incdir+tb
logic/rv_access_pkg.sv
logic/dmem_bus_pkg.sv
logic/access_decoder.sv
logic/access_queue.sv
logic/load_align.sv
logic/wb_access_master.sv
logic/lsu_top.sv
tb/lsu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the load/store unit testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module lsu_tb -f files.f -o lsu_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/lsu_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qF 'All tests passed!' <<< "$sim_out"; then
    exit 0
else
    echo "pass message not found in simulation output"
    exit 1
fi

// ==== tb/lsu_ref.svh ====
`ifndef LSU_REF_SVH
`define LSU_REF_SVH

// galois form of x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0]) begin
        next = next ^ 32'h8020_0003;
    end
    return next;
endfunction

// power-up contents of the data memory
function automatic word_t fill_word(input logic [3:0] idx);
    return ({28'd0, idx} + 32'd1) * 32'h9e37_79b9;
endfunction

function automatic logic ref_fault(input logic is_store, input funct3_t f3,
                                   input byte_addr_t addr);
    logic legal;
    logic misaligned;
    logic mapped;
    legal = f3 inside {F3_BYTE, F3_HALF, F3_WORD, F3_BYTE_U, F3_HALF_U};
    // no unsigned stores in the isa
    if (is_store && (f3 == F3_BYTE_U || f3 == F3_HALF_U)) begin
        legal = 1'b0;
    end
    misaligned = ((f3 == F3_HALF || f3 == F3_HALF_U) && addr[0])
              || (f3 == F3_WORD && addr[1:0] != 2'b00);
    mapped = (addr[31:28] == DMEM_REGION_A) || (addr[31:28] == DMEM_REGION_B);
    return !legal || misaligned || !mapped;
endfunction

function automatic byte_lanes_t ref_lanes(input funct3_t f3, input byte_offset_t off);
    byte_lanes_t lanes;
    int          size;
    int          first;
    size  = 1 << f3[1:0];
    first = int'(off);
    for (int i = 0; i < 4; i++) begin
        lanes[i] = (i >= first) && (i < first + size);
    end
    return lanes;
endfunction

// byte i of the bus word carries byte i-off of the store data
function automatic word_t ref_store_data(input word_t wdata, input byte_offset_t off);
    word_t out;
    int    first;
    out   = '0;
    first = int'(off);
    for (int i = 0; i < 4; i++) begin
        if (i >= first) begin
            out[8*i +: 8] = wdata[8*(i-first) +: 8];
        end
    end
    return out;
endfunction

function automatic word_t merge_lanes(input word_t old, input word_t data,
                                      input byte_lanes_t sel);
    word_t merged;
    merged = old;
    for (int i = 0; i < 4; i++) begin
        if (sel[i]) begin
            merged[8*i +: 8] = data[8*i +: 8];
        end
    end
    return merged;
endfunction

function automatic word_t ref_load(input word_t word, input funct3_t f3,
                                   input byte_offset_t off);
    logic [7:0]  b;
    logic [15:0] h;
    int          first;
    first = int'(off);
    b     = word[8*first +: 8];
    h     = '0;
    if (first <= 2) begin
        h = word[8*first +: 16];
    end
    case (f3)
        F3_BYTE:   return {{24{b[7]}}, b};
        F3_HALF:   return {{16{h[15]}}, h};
        F3_BYTE_U: return {24'd0, b};
        F3_HALF_U: return {16'd0, h};
        F3_WORD:   return word;
        default:   return '0;
    endcase
endfunction

`endif

// ==== tb/lsu_tb.sv ====
`default_nettype none

module lsu_tb;
    import rv_access_pkg::*;
    import dmem_bus_pkg::*;

    `include "lsu_ref.svh"

    localparam int NUM_CMDS       = 400;
    localparam int TIMEOUT_CYCLES = NUM_CMDS * 12 + 100;

    // one expected wishbone cycle, with the wait states the slave inserts
    typedef struct packed {
        logic        we;
        word_addr_t  adr;
        byte_lanes_t sel;
        word_t       dat_w;
        logic [1:0]  waits;
    } bus_exp_t;

    logic     clk = 1'b0;
    logic     rst_n;
    lsu_cmd_t cmd;
    logic     cmd_valid;
    logic     cmd_ready;
    lsu_rsp_t rsp;
    logic     rsp_valid;
    wb_req_t  wb_req;
    word_t    wb_dat_r = '0;
    logic     wb_ack = 1'b0;

    logic [31:0] lfsr_state;
    word_t       slave_mem [16];
    word_t       shadow_mem [16];
    lsu_rsp_t    exp_rsp [$];
    bus_exp_t    exp_bus [$];
    int          cycle_count = 0;
    int          rsp_count = 0;
    int          stall_cycles = 0;
    int          wait_left = -1;

    lsu_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .wb_req    (wb_req),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack)
    );

    always #10 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic value_error(input string name, input word_t got, input word_t exp);
        fail_run($sformatf("[ERROR] t=%0t %s got %h expected %h", $time, name, got, exp));
    endtask

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits       = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    // mostly legal and aligned, small window in both dmem mirrors
    function automatic lsu_cmd_t make_cmd();
        lsu_cmd_t     c;
        funct3_t      f3;
        byte_offset_t off;
        region_t      region;
        c.is_store = 1'(take_bits(1));
        f3         = 3'(take_bits(3));
        if (f3 inside {3'd3, 3'd6, 3'd7} && take_bits(2) != 32'd0) begin
            f3 = F3_WORD;
        end
        if (c.is_store && (f3 == F3_BYTE_U || f3 == F3_HALF_U) && take_bits(1) != 32'd0) begin
            f3 = f3 & 3'b011;
        end
        off = 2'(take_bits(2));
        if (take_bits(2) != 32'd0) begin
            if (f3 == F3_WORD) begin
                off = 2'b00;
            end else if (f3[1:0] == 2'b01) begin
                off[0] = 1'b0;
            end
        end
        region = (take_bits(1) != 32'd0) ? DMEM_REGION_B : DMEM_REGION_A;
        // even nibbles are never mapped
        if (take_bits(4) == 32'd0) begin
            region = {3'(take_bits(3)), 1'b0};
        end
        c.funct3 = f3;
        c.addr   = {region, 22'd0, 4'(take_bits(4)), off};
        c.wdata  = take_bits(32);
        return c;
    endfunction

    function automatic lsu_rsp_t ref_response(input lsu_cmd_t c, input word_t current);
        lsu_rsp_t r;
        r.fault = ref_fault(c.is_store, c.funct3, c.addr);
        r.data  = '0;
        if (!r.fault && !c.is_store) begin
            r.data = ref_load(current, c.funct3, c.addr[1:0]);
        end
        return r;
    endfunction

    // shadow memory follows acceptance order
    task automatic record_accept(input lsu_cmd_t c);
        lsu_rsp_t   r;
        bus_exp_t   b;
        logic [3:0] idx;
        idx = c.addr[5:2];
        r   = ref_response(c, shadow_mem[idx]);
        exp_rsp.push_back(r);
        if (!r.fault) begin
            b.we    = c.is_store;
            b.adr   = c.addr[31:2];
            b.sel   = ref_lanes(c.funct3, c.addr[1:0]);
            b.dat_w = ref_store_data(c.wdata, c.addr[1:0]);
            b.waits = 2'(take_bits(2));
            exp_bus.push_back(b);
            if (c.is_store) begin
                shadow_mem[idx] = merge_lanes(shadow_mem[idx], b.dat_w, b.sel);
            end
        end
    endtask

    initial begin : stimulus
        int gap;
        rst_n      = 1'b0;
        cmd_valid  = 1'b0;
        cmd        = '0;
        lfsr_state = 32'h5e8a_d910;
        for (int i = 0; i < 16; i++) begin
            shadow_mem[i] = fill_word(4'(i));
        end
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        assert (!wb_req.cyc && !wb_req.stb) else fail_run("bus cycle active after reset");
        assert (!rsp_valid) else fail_run("response valid right after reset");
        assert (cmd_ready) else fail_run("cmd_ready low right after reset");

        for (int n = 0; n < NUM_CMDS; n++) begin
            // back-to-back burst in the middle fills the queue
            gap = (n >= 150 && n < 250) ? 0 : int'(take_bits(2));
            repeat (gap) @(negedge clk);
            cmd       = make_cmd();
            cmd_valid = 1'b1;
            while (!cmd_ready) begin
                stall_cycles++;
                @(negedge clk);
            end
            record_accept(cmd);
            @(negedge clk);
            cmd_valid = 1'b0;
        end

        wait (rsp_count == NUM_CMDS);
        @(negedge clk);
        if (exp_rsp.size() == 0 && exp_bus.size() == 0 && stall_cycles > 0 && cmd_ready) begin
            $display("All tests passed!");
            $finish;
        end else begin
            fail_run($sformatf("end of run: %0d responses and %0d bus cycles missing, %0d stalls",
                               exp_rsp.size(), exp_bus.size(), stall_cycles));
        end
    end

    always @(negedge clk) begin : compare_rsp
        lsu_rsp_t expected;
        if (rst_n && rsp_valid) begin
            assert (exp_rsp.size() > 0) else fail_run("response arrived with no command pending");
            expected = exp_rsp.pop_front();
            assert (rsp.fault == expected.fault)
                else value_error("rsp.fault", 32'(rsp.fault), 32'(expected.fault));
            if (!expected.fault) begin
                assert (rsp.data == expected.data)
                    else value_error("rsp.data", rsp.data, expected.data);
            end
            rsp_count++;
        end
    end

    // wishbone slave, ack driven on the falling edge
    always @(negedge clk) begin : slave_model
        bus_exp_t   expected;
        logic [3:0] idx;
        if (!rst_n) begin
            wb_ack    = 1'b0;
            wait_left = -1;
            for (int i = 0; i < 16; i++) begin
                slave_mem[i] = fill_word(4'(i));
            end
        end else if (wb_ack) begin
            assert (!wb_req.cyc) else fail_run("cyc still high in the cycle after ack");
            wb_ack = 1'b0;
        end else if (wb_req.cyc && wb_req.stb) begin
            if (wait_left < 0) begin
                assert (exp_bus.size() > 0) else fail_run("bus cycle started for no mapped access");
                wait_left = int'(exp_bus[0].waits);
            end
            if (wait_left == 0) begin
                expected = exp_bus.pop_front();
                assert (wb_req.we == expected.we)
                    else value_error("wb_req.we", 32'(wb_req.we), 32'(expected.we));
                assert (wb_req.adr == expected.adr)
                    else value_error("wb_req.adr", 32'(wb_req.adr), 32'(expected.adr));
                assert (wb_req.sel == expected.sel)
                    else value_error("wb_req.sel", 32'(wb_req.sel), 32'(expected.sel));
                idx = wb_req.adr[3:0];
                if (wb_req.we) begin
                    assert (wb_req.dat_w == expected.dat_w)
                        else value_error("wb_req.dat_w", wb_req.dat_w, expected.dat_w);
                    slave_mem[idx] = merge_lanes(slave_mem[idx], wb_req.dat_w, wb_req.sel);
                end else begin
                    wb_dat_r = slave_mem[idx];
                end
                wb_ack    = 1'b1;
                wait_left = -1;
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            fail_run($sformatf("timeout after %0d cycles with %0d of %0d responses",
                               cycle_count, rsp_count, NUM_CMDS));
        end
    end

endmodule

`default_nettype wire

// ==== logic/lsu_top.sv ====
`default_nettype none

module lsu_top #(
    parameter int DEPTH = dmem_bus_pkg::QUEUE_DEPTH
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  rv_access_pkg::lsu_cmd_t cmd,
    input  logic                    cmd_valid,
    output logic                    cmd_ready,
    output rv_access_pkg::lsu_rsp_t rsp,
    output logic                    rsp_valid,
    output dmem_bus_pkg::wb_req_t   wb_req,
    input  rv_access_pkg::word_t    wb_dat_r,
    input  logic                    wb_ack
);
    import rv_access_pkg::*;

    logic        push;
    logic        full;
    logic        pop;
    logic        nonempty;
    access_req_t dec_req;
    access_req_t head;

    access_decoder u_decoder (
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .push      (push),
        .req       (dec_req),
        .full      (full)
    );

    access_queue #(
        .DEPTH (DEPTH)
    ) u_queue (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (push),
        .req_in   (dec_req),
        .pop      (pop),
        .head     (head),
        .nonempty (nonempty),
        .full     (full)
    );

    wb_access_master u_master (
        .clk       (clk),
        .rst_n     (rst_n),
        .head      (head),
        .nonempty  (nonempty),
        .pop       (pop),
        .wb_req    (wb_req),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .rsp       (rsp),
        .rsp_valid (rsp_valid)
    );

endmodule

`default_nettype wire

// ==== logic/wb_access_master.sv ====
`default_nettype none

module wb_access_master (
    input  logic                       clk,
    input  logic                       rst_n,
    input  rv_access_pkg::access_req_t head,
    input  logic                       nonempty,
    output logic                       pop,
    output dmem_bus_pkg::wb_req_t      wb_req,
    input  rv_access_pkg::word_t       wb_dat_r,
    input  logic                       wb_ack,
    output rv_access_pkg::lsu_rsp_t    rsp,
    output logic                       rsp_valid
);
    import rv_access_pkg::*;
    import dmem_bus_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUS,
        ST_RESPOND
    } state_t;

    state_t      state;
    access_req_t cur;
    word_t       ld_result;

    load_align u_load_align (
        .data     (wb_dat_r),
        .funct3   (cur.funct3),
        .offset   (cur.offset),
        .is_store (cur.is_store),
        .result   (ld_result)
    );

    assign pop       = (state == ST_IDLE) && nonempty;
    assign rsp_valid = (state == ST_RESPOND);

    // bus fields come straight from the held access
    assign wb_req.cyc   = (state == ST_BUS);
    assign wb_req.stb   = (state == ST_BUS);
    assign wb_req.we    = cur.is_store;
    assign wb_req.adr   = cur.word_addr;
    assign wb_req.dat_w = cur.wdata;
    assign wb_req.sel   = cur.lanes;

    always_ff @(posedge clk) begin
        if (pop) begin
            cur <= head;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (nonempty) begin
                        // a fault skips the bus entirely
                        state <= head.fault ? ST_RESPOND : ST_BUS;
                    end
                end
                ST_BUS: begin
                    if (wb_ack) begin
                        state <= ST_RESPOND;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // response payload, loaded at pop for a fault or at ack
    always_ff @(posedge clk) begin
        if (pop && head.fault) begin
            rsp.data  <= '0;
            rsp.fault <= 1'b1;
        end else if (state == ST_BUS && wb_ack) begin
            rsp.data  <= ld_result;
            rsp.fault <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) wb_req.stb |-> wb_req.cyc)
        else $error("wishbone stb without cyc");

    // classic cycle holds the request until ack is seen
    assert property (@(posedge clk) disable iff (!rst_n)
        (wb_req.cyc && !wb_ack) |=> (wb_req.cyc && $stable(wb_req)))
        else $error("wishbone request changed before ack");

endmodule

`default_nettype wire

// ==== logic/load_align.sv ====
`default_nettype none

module load_align (
    input  rv_access_pkg::word_t        data,
    input  rv_access_pkg::funct3_t      funct3,
    input  rv_access_pkg::byte_offset_t offset,
    input  logic                        is_store,
    output rv_access_pkg::word_t        result
);
    import rv_access_pkg::*;

    word_t shifted;

    // bring the addressed byte or halfword down to bit 0
    assign shifted = data >> {offset, 3'b000};

    always_comb begin
        if (is_store) begin
            result = '0;
        end else begin
            case (funct3)
                F3_BYTE:   result = {{24{shifted[7]}}, shifted[7:0]};
                F3_HALF:   result = {{16{shifted[15]}}, shifted[15:0]};
                F3_BYTE_U: result = {24'd0, shifted[7:0]};
                F3_HALF_U: result = {16'd0, shifted[15:0]};
                default:   result = shifted;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/access_queue.sv ====
`default_nettype none

module access_queue #(
    parameter int DEPTH = dmem_bus_pkg::QUEUE_DEPTH
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       push,
    input  rv_access_pkg::access_req_t req_in,
    input  logic                       pop,
    output rv_access_pkg::access_req_t head,
    output logic                       nonempty,
    output logic                       full
);
    import rv_access_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    access_req_t       mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;

    assign head     = mem[rd_ptr];
    assign nonempty = (count != '0);
    assign full     = (count == CNT_W'(DEPTH));

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= req_in;
        end
    end

    // pointers wrap explicitly, depth need not be a power of two
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // decoder holds off on full, master only pops a nonempty queue
    assert property (@(posedge clk) disable iff (!rst_n) !(push && full))
        else $error("push into full access queue");
    assert property (@(posedge clk) disable iff (!rst_n) !(pop && !nonempty))
        else $error("pop from empty access queue");

endmodule

`default_nettype wire

// ==== logic/access_decoder.sv ====
`default_nettype none

module access_decoder (
    input  rv_access_pkg::lsu_cmd_t    cmd,
    input  logic                       cmd_valid,
    output logic                       cmd_ready,
    output logic                       push,
    output rv_access_pkg::access_req_t req,
    input  logic                       full
);
    import rv_access_pkg::*;
    import dmem_bus_pkg::*;

    region_t      region;
    byte_offset_t offset;
    logic         bad_funct3;
    logic         misaligned;
    logic         unmapped;
    logic         fault;
    byte_lanes_t  lanes;

    assign region = cmd.addr[31:28];
    assign offset = cmd.addr[1:0];

    // faulting commands are still queued so responses stay in order
    assign cmd_ready = !full;
    assign push      = cmd_valid && !full;

    always_comb begin
        bad_funct3 = 1'b0;
        misaligned = 1'b0;
        lanes      = '0;
        case (cmd.funct3)
            F3_BYTE: begin
                lanes = byte_lanes_t'(4'b0001 << offset);
            end
            F3_BYTE_U: begin
                lanes      = byte_lanes_t'(4'b0001 << offset);
                bad_funct3 = cmd.is_store;
            end
            F3_HALF: begin
                lanes      = byte_lanes_t'(4'b0011 << offset);
                misaligned = offset[0];
            end
            F3_HALF_U: begin
                lanes      = byte_lanes_t'(4'b0011 << offset);
                misaligned = offset[0];
                bad_funct3 = cmd.is_store;
            end
            F3_WORD: begin
                lanes      = 4'b1111;
                misaligned = (offset != 2'd0);
            end
            default: begin
                bad_funct3 = 1'b1;
            end
        endcase

        unmapped = (region != DMEM_REGION_A) && (region != DMEM_REGION_B);
        fault    = bad_funct3 || misaligned || unmapped;

        // lanes only mean something for a good access
        if (fault) begin
            lanes = '0;
        end

        if (cmd_valid && !fault) begin
            assert (lanes != '0)
                else $error("decoded access without byte lanes");
        end
    end

    always_comb begin
        req.fault     = fault;
        req.is_store  = cmd.is_store;
        req.funct3    = cmd.funct3;
        req.word_addr = cmd.addr[31:2];
        req.offset    = offset;
        req.lanes     = lanes;
        // move store bytes onto their lanes
        req.wdata     = cmd.wdata << {offset, 3'b000};
    end

endmodule

`default_nettype wire

// ==== logic/dmem_bus_pkg.sv ====
`default_nettype none

package dmem_bus_pkg;

    typedef logic [29:0] word_addr_t;

    // top address nibble
    typedef logic [3:0] region_t;

    // data memory is mirrored at nibbles 1 and 3
    localparam region_t DMEM_REGION_A = 4'h1;
    localparam region_t DMEM_REGION_B = 4'h3;

    localparam int QUEUE_DEPTH = 4;

    // wishbone classic master outputs
    typedef struct packed {
        logic                       cyc;
        logic                       stb;
        logic                       we;
        word_addr_t                 adr;
        rv_access_pkg::word_t       dat_w;
        rv_access_pkg::byte_lanes_t sel;
    } wb_req_t;

endpackage

`default_nettype wire

// ==== logic/rv_access_pkg.sv ====
`default_nettype none

package rv_access_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] byte_addr_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [3:0]  byte_lanes_t;
    typedef logic [1:0]  byte_offset_t;

    // load/store funct3 codes, stores use only the signed ones
    localparam funct3_t F3_BYTE   = 3'd0;
    localparam funct3_t F3_HALF   = 3'd1;
    localparam funct3_t F3_WORD   = 3'd2;
    localparam funct3_t F3_BYTE_U = 3'd4;
    localparam funct3_t F3_HALF_U = 3'd5;

    // command as issued by the core
    typedef struct packed {
        logic       is_store;
        funct3_t    funct3;
        byte_addr_t addr;
        word_t      wdata;
    } lsu_cmd_t;

    // decoded access, word address is addr[31:2]
    typedef struct packed {
        logic         fault;
        logic         is_store;
        funct3_t      funct3;
        logic [29:0]  word_addr;
        byte_offset_t offset;
        byte_lanes_t  lanes;
        word_t        wdata;
    } access_req_t;

    typedef struct packed {
        word_t data;
        logic  fault;
    } lsu_rsp_t;

endpackage

`default_nettype wire
